//--- filelist.f
hdl/rv_isa_pkg.sv
hdl/core_pipe_pkg.sv
hdl/pipe_reg.sv
hdl/ifu.sv
hdl/id_ctrl.sv
hdl/regs.sv
hdl/alu.sv
hdl/core.sv
testbench/core_assert.sv
testbench/tb_core.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
(verilator --binary --timing --assert --top-module tb_core -f filelist.f -o sim_core \
    && ./obj_dir/sim_core) > sim.log 2>&1
cat sim.log
grep -q "Verification passed" sim.log && echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }

//--- testbench/tb_core.sv
module tb_core;

    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam int PERIOD    = 100;
    localparam int ROM_WORDS = 256;
    // directed programs, three random programs, reset and drain per test
    localparam int PROG_INSTS = 60 + 3 * 40;
    localparam int WATCHDOG   = (2 * PROG_INSTS + 8 * 40) * PERIOD;

    logic    clk;
    logic    rst_n;
    word_t   inst;
    word_t   rom_addr;
    logic    rom_en;
    retire_t retire;

    word_t   rom [ROM_WORDS];
    word_t   prog_q[$];
    retire_t exp_q[$];
    int      fetch_cycle [ROM_WORDS];
    int      cycle;
    int      err_count;
    logic    active;
    logic [31:0] lfsr_state;

    core #(.RESET_PC(32'h0)) DUT (
        .clk(clk), .rst_n_i(rst_n), .inst_i(inst),
        .rom_addr_o(rom_addr), .rom_en_o(rom_en), .retire_o(retire)
    );

    // combinational ROM read
    assign inst = rom[rom_addr[9:2]];

    always #(PERIOD / 2) clk = ~clk;

    task automatic check(string name, word_t actual, word_t expected);
        if (actual !== expected) begin
            err_count++;
            $display("[FAIL] %0t %s: got %h expected %h", $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic word_t enc_lui(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic word_t enc_jal(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic word_t ref_op(logic [2:0] f3, word_t x, word_t y);
        case (f3)
            3'd0: return x + y;
            3'd1: return x << y[4:0];
            3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd4: return x ^ y;
            3'd5: return x >> y[4:0];
            3'd6: return x | y;
            3'd7: return x & y;
            default: return '0;
        endcase
    endfunction

    // executes the ROM program from pc 0 and queues the expected retires
    task automatic run_reference(int len);
        word_t      rf [32];
        word_t      pc;
        word_t      nxt;
        word_t      w;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      val;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       legal;
        retire_t    rec;
        int         guard;
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
        pc = '0;
        guard = 0;
        while (pc < len * 4 && guard < 1000) begin
            w   = rom[pc[9:2]];
            a   = rf[w[19:15]];
            b   = rf[w[24:20]];
            f3  = w[14:12];
            f7  = w[31:25];
            imm = {{20{w[31]}}, w[31:20]};
            nxt = pc + 4;
            val = '0;
            legal = 1'b1;
            case (w[6:0])
                OPC_OP: begin
                    legal = (f7 == 7'h00 && f3 != 3'd3) || (f7 == 7'h20 && f3 == 3'd0);
                    val = (f7 == 7'h20) ? a - b : ref_op(f3, a, b);
                end
                OPC_OP_IMM: begin
                    legal = !(f3 == 3'd1 || f3 == 3'd3 || f3 == 3'd5);
                    val = ref_op(f3, a, imm);
                end
                OPC_LUI: val = {w[31:12], 12'b0};
                OPC_JAL: begin
                    val = pc + 4;
                    nxt = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                default: legal = 1'b0;
            endcase
            rec.valid = 1'b1;
            rec.we    = legal && (w[11:7] != 5'd0);
            rec.rd    = w[11:7];
            rec.value = val;
            rec.pc    = pc;
            exp_q.push_back(rec);
            if (rec.we) begin
                rf[rec.rd] = val;
            end
            pc = nxt;
            guard++;
        end
    endtask

    task automatic load_rom();
        for (int i = 0; i < ROM_WORDS; i++) begin
            // filler writes x0, immediate taken from the address
            rom[i] = (i < prog_q.size()) ? prog_q[i] : enc_i(12'(i * 4), 5'd0, F3_ADD_SUB, 5'd0);
        end
    endtask

    task automatic do_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #1;
            check("retire_o.valid in reset", 32'(retire.valid), 32'd0);
            check("rom_en_o in reset", 32'(rom_en), 32'd0);
        end
        rst_n = 1'b1;
    endtask

    task automatic run_program();
        int len;
        int waited;
        len = prog_q.size();
        load_rom();
        exp_q.delete();
        run_reference(len);
        do_reset();
        active = 1'b1;
        waited = 0;
        while (exp_q.size() != 0 && waited < 2 * len + 30) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d expected retires never appeared", exp_q.size());
            $display("Verification failed");
            $fatal(1);
        end
        active = 1'b0;
    endtask

    // retire monitor with fetch-to-retire latency
    always @(negedge clk) begin
        retire_t e;
        cycle++;
        if (rom_en) begin
            fetch_cycle[rom_addr[9:2]] = cycle;
        end
        if (active && retire.valid) begin
            e = exp_q.pop_front();
            check("retire_o.pc", retire.pc, e.pc);
            check("retire_o.we", 32'(retire.we), 32'(e.we));
            if (e.we) begin
                check("retire_o.rd", 32'(retire.rd), 32'(e.rd));
                check("retire_o.value", retire.value, e.value);
            end
            check("retire latency", 32'(cycle - fetch_cycle[retire.pc[9:2]]), 32'd4);
            if (exp_q.size() == 0) begin
                active = 1'b0;
            end
        end
    end

    task automatic test_reset();
        prog_q.delete();
        load_rom();
        do_reset();
        @(posedge clk);
        #1;
        check("rom_en_o after reset", 32'(rom_en), 32'd1);
        check("rom_addr_o first fetch", rom_addr, 32'd0);
        for (int i = 1; i < 4; i++) begin
            @(posedge clk);
            #1 check("rom_addr_o step", rom_addr, 32'(i * 4));
        end
    endtask

    task automatic test_alu();
        prog_q = '{enc_i(12'hffb, 5'd0, F3_ADD_SUB, 5'd1), enc_i(12'd100, 5'd0, F3_ADD_SUB, 5'd2),
                   enc_lui(20'h80001, 5'd3), enc_i(12'd3, 5'd0, F3_ADD_SUB, 5'd4),
                   enc_i(12'h0f0, 5'd0, F3_ADD_SUB, 5'd5), enc_i(12'h7ff, 5'd0, F3_ADD_SUB, 5'd6),
                   enc_r(F7_BASE, 5'd2, 5'd1, F3_ADD_SUB, 5'd10),
                   enc_r(F7_ALT, 5'd2, 5'd1, F3_ADD_SUB, 5'd11),
                   enc_r(F7_BASE, 5'd6, 5'd5, F3_AND, 5'd12),
                   enc_r(F7_BASE, 5'd6, 5'd5, F3_OR, 5'd13),
                   enc_r(F7_BASE, 5'd6, 5'd1, F3_XOR, 5'd14),
                   enc_r(F7_BASE, 5'd2, 5'd1, F3_SLT, 5'd15),
                   enc_r(F7_BASE, 5'd1, 5'd2, F3_SLT, 5'd16),
                   enc_r(F7_BASE, 5'd4, 5'd3, F3_SLL, 5'd17),
                   enc_r(F7_BASE, 5'd4, 5'd1, F3_SRL, 5'd18),
                   enc_r(F7_BASE, 5'd4, 5'd3, F3_SRL, 5'd19),
                   enc_i(12'h0ff, 5'd1, F3_AND, 5'd20), enc_i(12'h800, 5'd2, F3_OR, 5'd21),
                   enc_i(12'hfff, 5'd5, F3_XOR, 5'd22), enc_i(12'hffe, 5'd1, F3_SLT, 5'd23)};
        run_program();
    endtask

    task automatic test_forward();
        prog_q = '{enc_i(12'd7, 5'd0, F3_ADD_SUB, 5'd1), enc_i(12'd1, 5'd1, F3_ADD_SUB, 5'd2),
                   enc_r(F7_BASE, 5'd1, 5'd2, F3_ADD_SUB, 5'd3),
                   enc_r(F7_BASE, 5'd1, 5'd3, F3_SLL, 5'd4),
                   enc_i(12'd0, 5'd0, F3_ADD_SUB, 5'd9),
                   enc_r(F7_ALT, 5'd3, 5'd4, F3_ADD_SUB, 5'd5),
                   enc_i(12'd0, 5'd0, F3_ADD_SUB, 5'd9), enc_i(12'd0, 5'd0, F3_ADD_SUB, 5'd9),
                   enc_r(F7_BASE, 5'd5, 5'd4, F3_XOR, 5'd6),
                   enc_i(12'd5, 5'd6, F3_ADD_SUB, 5'd6), enc_i(12'd5, 5'd6, F3_ADD_SUB, 5'd6),
                   enc_r(F7_BASE, 5'd6, 5'd6, F3_ADD_SUB, 5'd7)};
        run_program();
    endtask

    task automatic test_x0();
        prog_q = '{enc_i(12'd5, 5'd0, F3_ADD_SUB, 5'd0), enc_i(12'd9, 5'd0, F3_ADD_SUB, 5'd1),
                   enc_r(F7_BASE, 5'd1, 5'd1, F3_ADD_SUB, 5'd0),
                   enc_i(12'd0, 5'd0, F3_ADD_SUB, 5'd5),
                   enc_r(F7_BASE, 5'd0, 5'd0, F3_OR, 5'd6), enc_lui(20'h12345, 5'd0)};
        run_program();
    endtask

    task automatic test_jal();
        prog_q = '{enc_i(12'd3, 5'd0, F3_ADD_SUB, 5'd1), enc_jal(21'd12, 5'd7),
                   enc_i(12'd1, 5'd0, F3_ADD_SUB, 5'd2), enc_i(12'd2, 5'd0, F3_ADD_SUB, 5'd3),
                   enc_r(F7_BASE, 5'd1, 5'd7, F3_ADD_SUB, 5'd8), enc_jal(21'd8, 5'd0),
                   enc_i(12'd4, 5'd0, F3_ADD_SUB, 5'd4), enc_r(F7_BASE, 5'd8, 5'd7, F3_OR, 5'd9)};
        run_program();
    endtask

    task automatic test_random();
        logic [2:0] f3;
        logic [6:0] f7;
        for (int p = 0; p < 3; p++) begin
            prog_q.delete();
            for (int i = 0; i < 40; i++) begin
                case (rand_bits(2))
                    0, 1: begin
                        f3 = 3'(rand_bits(3));
                        f7 = (f3 == F3_ADD_SUB && rand_bits(1) == 1) ? F7_ALT : F7_BASE;
                        prog_q.push_back(enc_r(f7, 5'(rand_bits(4)), 5'(rand_bits(4)), f3,
                                               5'(rand_bits(4))));
                    end
                    2: prog_q.push_back(enc_i(12'(rand_bits(12)), 5'(rand_bits(4)),
                                              3'(rand_bits(3)), 5'(rand_bits(4))));
                    default: prog_q.push_back(enc_lui(20'(rand_bits(20)), 5'(rand_bits(4))));
                endcase
            end
            run_program();
        end
    endtask

    initial begin
        #(WATCHDOG);
        $display("watchdog expired, the run did not finish in time");
        $display("Verification failed");
        $fatal(1);
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        active = 1'b0;
        cycle = 0;
        err_count = 0;
        lfsr_state = 32'h1a89;
        for (int i = 0; i < ROM_WORDS; i++) begin
            fetch_cycle[i] = 0;
        end
        test_reset();
        test_alu();
        test_forward();
        test_x0();
        test_jal();
        test_random();
        if (err_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- testbench/core_assert.sv
module core_assert (
    input logic                   clk,
    input logic                   rst_n_i,
    input logic                   rom_en_i,
    input rv_isa_pkg::word_t      rom_addr_i,
    input logic                   wr_en_i,
    input rv_isa_pkg::reg_addr_t  wr_addr_i,
    input core_pipe_pkg::retire_t retire_i
);

    // fetch enable is registered, so it drops one edge into reset
    a_rom_en_reset: assert property (@(posedge clk) !rst_n_i && $past(!rst_n_i) |-> !rom_en_i)
        else $error("rom_en_o high during reset");

    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        wr_en_i |-> wr_addr_i != 5'd0)
        else $error("register write to x0");

    // flushed slots never retire, so a retiring pc was fetched four cycles back
    a_retire_pc: assert property (@(posedge clk) disable iff (!rst_n_i)
        retire_i.valid |-> retire_i.pc == $past(rom_addr_i, 4))
        else $error("retired pc does not match fetch four cycles earlier");

endmodule

bind core core_assert u_core_assert (
    .clk(clk), .rst_n_i(rst_n_i), .rom_en_i(rom_en_o), .rom_addr_i(rom_addr_o),
    .wr_en_i(wb_valid && wb_q.we), .wr_addr_i(wb_q.rd), .retire_i(retire_o)
);

//--- hdl/core.sv
module core #(
    parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  rv_isa_pkg::word_t      inst_i,
    output rv_isa_pkg::word_t      rom_addr_o,
    output logic                   rom_en_o,
    output core_pipe_pkg::retire_t retire_o
);

    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    // fetch
    word_t     pc;
    logic      fetch_en;
    logic      redirect;
    word_t     target;
    if_id_t    if_id_d;
    if_id_t    if_id_q;
    logic      if_valid;

    // decode and register file
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    logic      id_valid;
    logic      ex_valid;

    // execute, memory, write-back
    ex_wb_t    ex_wb;
    ex_wb_t    mem_q;
    logic      mem_valid;
    ex_wb_t    wb_q;
    logic      wb_valid;

    assign rom_addr_o = pc;
    assign rom_en_o   = fetch_en;
    assign if_id_d    = '{valid: fetch_en, pc: pc, inst: inst_i};

    ifu #(.RESET_PC(RESET_PC)) u1_ifu (
        .clk(clk), .rst_n_i(rst_n_i),
        .redirect_i(redirect), .target_i(target),
        .pc_o(pc), .fetch_en_o(fetch_en)
    );

    // flushed slot behind a JAL
    pipe_reg #(.T(if_id_t)) u1_if_id (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(redirect),
        .d_i(if_id_d), .valid_i(fetch_en), .q_o(if_id_q), .valid_o(if_valid)
    );

    id_ctrl u2_id_ctrl (
        .if_id_i(if_id_q), .if_valid_i(if_valid),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_fwd_i(ex_wb), .mem_fwd_i(mem_q),
        .id_ex_o(id_ex_d), .id_valid_o(id_valid),
        .redirect_o(redirect), .target_o(target)
    );

    pipe_reg #(.T(id_ex_t)) u2_id_ex (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(1'b0),
        .d_i(id_ex_d), .valid_i(id_valid), .q_o(id_ex_q), .valid_o(ex_valid)
    );

    alu u3_alu (.id_ex_i(id_ex_q), .ex_wb_o(ex_wb));

    pipe_reg #(.T(ex_wb_t)) u3_ex_mem (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(1'b0),
        .d_i(ex_wb), .valid_i(ex_valid), .q_o(mem_q), .valid_o(mem_valid)
    );

    pipe_reg #(.T(ex_wb_t)) u4_mem_wb (
        .clk(clk), .rst_n_i(rst_n_i), .flush_i(1'b0),
        .d_i(mem_q), .valid_i(mem_valid), .q_o(wb_q), .valid_o(wb_valid)
    );

    regs u0_regs (
        .clk(clk), .rst_n_i(rst_n_i),
        .wr_en_i(wb_valid && wb_q.we), .wr_addr_i(wb_q.rd), .wr_data_i(wb_q.value),
        .rd_addr1_i(rs1_addr), .rd_addr2_i(rs2_addr),
        .rd_data1_o(rs1_data), .rd_data2_o(rs2_data)
    );

    assign retire_o = '{valid: wb_valid,
                        we:    wb_q.we,
                        rd:    wb_q.rd,
                        value: wb_q.value,
                        pc:    wb_q.pc};

endmodule

//--- hdl/alu.sv
module alu (
    input  core_pipe_pkg::id_ex_t id_ex_i,
    output core_pipe_pkg::ex_wb_t ex_wb_o
);

    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    word_t      a;
    word_t      b;
    logic [4:0] shamt;
    word_t      result;

    assign a     = id_ex_i.op_a;
    assign b     = id_ex_i.op_b;
    assign shamt = b[4:0];

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                // signed compare
                result = {31'b0, $signed(a) < $signed(b)};
            end
            ALU_SLL: begin
                result = a << shamt;
            end
            ALU_SRL: begin
                result = a >> shamt;
            end
            ALU_PASS_B: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign ex_wb_o = '{valid: id_ex_i.valid,
                       value: result,
                       we:    id_ex_i.we,
                       rd:    id_ex_i.rd,
                       pc:    id_ex_i.pc};

endmodule

//--- hdl/regs.sv
module regs (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  wr_en_i,
    input  rv_isa_pkg::reg_addr_t wr_addr_i,
    input  rv_isa_pkg::word_t     wr_data_i,
    input  rv_isa_pkg::reg_addr_t rd_addr1_i,
    input  rv_isa_pkg::reg_addr_t rd_addr2_i,
    output rv_isa_pkg::word_t     rd_data1_o,
    output rv_isa_pkg::word_t     rd_data2_o
);

    import rv_isa_pkg::*;

    word_t rf [1:31];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            rf[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 reads zero, same-cycle write passes straight through
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en_i && wr_addr_i == addr) begin
            return wr_data_i;
        end
        return rf[addr];
    endfunction

    assign rd_data1_o = read_port(rd_addr1_i);
    assign rd_data2_o = read_port(rd_addr2_i);

endmodule

//--- hdl/id_ctrl.sv
module id_ctrl (
    input  core_pipe_pkg::if_id_t if_id_i,
    input  logic                  if_valid_i,
    output rv_isa_pkg::reg_addr_t rs1_addr_o,
    output rv_isa_pkg::reg_addr_t rs2_addr_o,
    input  rv_isa_pkg::word_t     rs1_data_i,
    input  rv_isa_pkg::word_t     rs2_data_i,
    input  core_pipe_pkg::ex_wb_t ex_fwd_i,
    input  core_pipe_pkg::ex_wb_t mem_fwd_i,
    output core_pipe_pkg::id_ex_t id_ex_o,
    output logic                  id_valid_o,
    output logic                  redirect_o,
    output rv_isa_pkg::word_t     target_o
);

    import rv_isa_pkg::*;
    import core_pipe_pkg::*;

    word_t      inst;
    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_u;
    word_t      imm_j;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      op_a;
    word_t      op_b;
    alu_op_e    alu_op;
    logic       legal;
    logic       is_jal;
    logic       f7_base;

    // nearest producer wins
    function automatic word_t bypass(reg_addr_t addr, word_t rf_data,
                                     ex_wb_t ex_s, ex_wb_t mem_s);
        if (ex_s.valid && ex_s.we && ex_s.rd != '0 && ex_s.rd == addr) begin
            return ex_s.value;
        end
        if (mem_s.valid && mem_s.we && mem_s.rd != '0 && mem_s.rd == addr) begin
            return mem_s.value;
        end
        return rf_data;
    endfunction

    assign inst    = if_id_i.inst;
    assign opcode  = opcode_e'(inst[6:0]);
    assign rd      = inst[11:7];
    assign funct3  = inst[14:12];
    assign funct7  = inst[31:25];
    assign f7_base = (funct7 == F7_BASE);

    assign rs1_addr_o = inst[19:15];
    assign rs2_addr_o = inst[24:20];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    assign rs1_val = bypass(rs1_addr_o, rs1_data_i, ex_fwd_i, mem_fwd_i);
    assign rs2_val = bypass(rs2_addr_o, rs2_data_i, ex_fwd_i, mem_fwd_i);

    always_comb begin
        alu_op = ALU_ADD;
        legal  = 1'b0;
        is_jal = 1'b0;
        op_a   = rs1_val;
        op_b   = rs2_val;
        case (opcode)
            OPC_OP: begin
                legal = f7_base;
                case (funct3)
                    F3_ADD_SUB: begin
                        legal  = f7_base || (funct7 == F7_ALT);
                        alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    end
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SRL:  alu_op = ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: legal  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                op_b  = imm_i;
                legal = 1'b1;
                case (funct3)
                    F3_ADD_SUB: alu_op = ALU_ADD;
                    F3_SLT:     alu_op = ALU_SLT;
                    F3_XOR:     alu_op = ALU_XOR;
                    F3_OR:      alu_op = ALU_OR;
                    F3_AND:     alu_op = ALU_AND;
                    default:    legal  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                op_b   = imm_u;
                alu_op = ALU_PASS_B;
                legal  = 1'b1;
            end
            OPC_JAL: begin
                // link value pc + 4
                op_a   = if_id_i.pc;
                op_b   = 32'd4;
                is_jal = 1'b1;
                legal  = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // illegal encodings still retire, just without a write
    assign id_ex_o = '{valid:  if_valid_i,
                       op_a:   op_a,
                       op_b:   op_b,
                       alu_op: alu_op,
                       we:     if_valid_i && legal && (rd != '0),
                       rd:     rd,
                       pc:     if_id_i.pc};

    assign id_valid_o = if_valid_i;
    assign redirect_o = if_valid_i && is_jal;
    assign target_o   = if_id_i.pc + imm_j;

endmodule

//--- hdl/ifu.sv
module ifu #(
    parameter rv_isa_pkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              redirect_i,
    input  rv_isa_pkg::word_t target_i,
    output rv_isa_pkg::word_t pc_o,
    output logic              fetch_en_o
);

    import rv_isa_pkg::*;

    word_t pc_q;
    logic  fetch_en_q;

    // fetch starts the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fetch_en_q <= 1'b0;
        end else begin
            fetch_en_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            pc_q <= target_i;
        end else if (fetch_en_q) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o       = pc_q;
    assign fetch_en_o = fetch_en_q;

endmodule

//--- hdl/pipe_reg.sv
module pipe_reg #(
    parameter type T = core_pipe_pkg::ex_wb_t
) (
    input  logic clk,
    input  logic rst_n_i,
    input  logic flush_i,
    input  T     d_i,
    input  logic valid_i,
    output T     q_o,
    output logic valid_o
);

    T     data_q;
    logic valid_q;

    always_ff @(posedge clk) begin
        data_q <= d_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // payload valid follows the stage valid
    always_comb begin
        q_o       = data_q;
        q_o.valid = valid_q;
    end

    assign valid_o = valid_q;

endmodule

//--- hdl/core_pipe_pkg.sv
package core_pipe_pkg;

    import rv_isa_pkg::*;

    // fetch -> decode
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t inst;
    } if_id_t;

    // decode -> execute
    typedef struct packed {
        logic      valid;
        word_t     op_a;
        word_t     op_b;
        alu_op_e   alu_op;
        logic      we;
        reg_addr_t rd;
        word_t     pc;
    } id_ex_t;

    // execute -> memory -> write-back
    typedef struct packed {
        logic      valid;
        word_t     value;
        logic      we;
        reg_addr_t rd;
        word_t     pc;
    } ex_wb_t;

    // one retired instruction per cycle
    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t rd;
        word_t     value;
        word_t     pc;
    } retire_t;

endpackage

//--- hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    // funct3 codes, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7, alt selects SUB
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage
